// ==== sources.f ====
+incdir+.
iir_pkg.sv
dsp_mac.sv
iir_coef_regs.sv
iir_biquad_seq.sv
iir_filter_top.sv
tb_iir_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the biquad testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_iir_filter -f sources.f \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_iir_filter > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation did not complete, see $SIM_LOG"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$SIM_LOG"; then
    echo "Simulation reported failure, see $SIM_LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb_iir_filter.sv ====
// One sample in flight at a time; the model assumes coefficients only change while the filter is idle
`timescale 1ns/100ps
`include "iir_consts.svh"

module tb_iir_filter;

    import iir_pkg::*;

    localparam int N_IMPULSE  = 6;
    localparam int N_FEEDBACK = 8;
    localparam int N_RANDOM   = 60;
    localparam int N_FLOW     = 2;
    localparam int N_CLEAR    = 2;
    localparam int N_SAMPLES  = N_IMPULSE + N_FEEDBACK + N_RANDOM + N_FLOW + N_CLEAR;
    // Reset, registers, impulse, feedback, random, flow, clear
    localparam int N_APB      = 7 + 14 + 6 + 3 + 6 + 2 + 3;
    localparam int WATCHDOG_CYCLES = N_SAMPLES * (`IIR_LATENCY + 4) + N_APB * 4 + 200;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    sample_t     sample_in;
    logic        sample_in_valid;
    logic        sample_in_ready;
    sample_t     sample_out;
    logic        sample_out_valid;

    // Expected values and scoreboard state
    string       test_name;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        enabled;
    longint      cf [`IIR_TAPS];
    sample_t     mx1;
    sample_t     mx2;
    sample_t     my1;
    sample_t     my2;
    sample_t     model_y;
    sample_t     exp_q [$];
    int          time_q [$];
    sample_t     exp_head;
    int          lat_head;
    logic        in_flight;
    int          cyc;
    int          in_count;
    int          out_count;
    int          err_data;
    int          err_timing;
    int          err_proto;
    logic [31:0] rng_state;

    iir_filter_top iir_filter_top_i (
        .clk              (clk),
        .reset            (reset),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .sample_in_ready  (sample_in_ready),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Reference model and helpers
    // --------------------------------------------------
    function automatic sample_t model_output(input sample_t x0);
        longint sum;
        longint shifted;
        sum = cf[0] * longint'(x0) + cf[1] * longint'(mx1) + cf[2] * longint'(mx2)
            + cf[3] * longint'(my1) + cf[4] * longint'(my2);
        shifted = sum >>> `IIR_FRAC_W;
        return sample_t'(shifted[`IIR_SAMPLE_W-1:0]);
    endfunction

    function automatic logic [31:0] sext18(input logic [31:0] word);
        return {{14{word[17]}}, word[17:0]};
    endfunction

    function automatic logic is_mapped(input logic [7:0] addr);
        return (addr <= `REG_STATUS) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Every task starts and ends on a falling edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        exp_err = !is_mapped(addr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (addr == `REG_CTRL) begin
            enabled = data[`CTRL_ENABLE_BIT];
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected);
        exp_err   = !is_mapped(addr);
        exp_rdata = expected;
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_coef(input int idx, input logic [31:0] word);
        apb_write(`REG_COEF0 + 8'(4 * idx), word);
        cf[idx] = longint'(signed'(sext18(word)));
    endtask

    task automatic clear_history();
        apb_write(`REG_CTRL, 32'h3);
        mx1 = '0;
        mx2 = '0;
        my1 = '0;
        my2 = '0;
    endtask

    // Holds the sample until it is accepted
    task automatic send_sample(input sample_t value);
        sample_in       = value;
        sample_in_valid = 1'b1;
        while (!sample_in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        sample_in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Scoreboard queues the model result on each accepted sample
    always @(posedge clk) begin
        if (!reset && sample_in_valid && sample_in_ready) begin
            model_y = model_output(sample_in);
            mx2 = mx1;
            mx1 = sample_in;
            my2 = my1;
            my1 = model_y;
            exp_q.push_back(model_y);
            time_q.push_back(cyc);
            in_count++;
        end
        if (!reset && sample_out_valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            void'(time_q.pop_front());
            out_count++;
        end
        in_flight <= exp_q.size() != 0;
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
        lat_head  <= (time_q.size() != 0) ? time_q[0] : 0;
        cyc       <= cyc + 1;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    out_value_check: assert property (@(posedge clk) disable iff (reset)
        sample_out_valid && in_flight |-> sample_out == exp_head)
    else begin
        err_data++;
        $display("mismatch %s: sample_out expected %0d actual %0d",
                 test_name, $sampled(exp_head), $sampled(sample_out));
    end

    // Valid rises LATENCY edges after acceptance and is seen at the next edge
    latency_check: assert property (@(posedge clk) disable iff (reset)
        sample_out_valid && in_flight |-> cyc - lat_head == `IIR_LATENCY + 1)
    else begin
        err_timing++;
        $display("mismatch %s: latency expected %0d actual %0d", test_name,
                 `IIR_LATENCY, $sampled(cyc) - $sampled(lat_head) - 1);
    end

    spurious_out_check: assert property (@(posedge clk) disable iff (reset)
        sample_out_valid |-> in_flight)
    else begin
        err_proto++;
        $display("Error in %s: output pulse with no sample in process", test_name);
    end

    disabled_ready_check: assert property (@(posedge clk) disable iff (reset)
        !enabled |-> !sample_in_ready)
    else begin
        err_proto++;
        $display("Error in %s: input ready while the filter is disabled", test_name);
    end

    busy_ready_check: assert property (@(posedge clk) disable iff (reset)
        in_flight |-> !sample_in_ready)
    else begin
        err_proto++;
        $display("Error in %s: input ready while a sample is in process", test_name);
    end

    pready_check: assert property (@(posedge clk) disable iff (reset)
        psel |-> pready)
    else begin
        err_proto++;
        $display("Error in %s: pready low during an APB transfer", test_name);
    end

    pslverr_check: assert property (@(posedge clk) disable iff (reset)
        psel && penable |-> pslverr == exp_err)
    else begin
        err_proto++;
        $display("mismatch %s: pslverr expected %0b actual %0b",
                 test_name, $sampled(exp_err), $sampled(pslverr));
    end

    prdata_check: assert property (@(posedge clk) disable iff (reset)
        psel && penable && !pwrite |-> prdata == exp_rdata)
    else begin
        err_data++;
        $display("mismatch %s: prdata expected %h actual %h",
                 test_name, $sampled(exp_rdata), $sampled(prdata));
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        sample_in       = '0;
        sample_in_valid = 1'b0;
        test_name       = "reset";
        exp_rdata       = '0;
        exp_err         = 1'b0;
        enabled         = 1'b0;
        mx1             = '0;
        mx2             = '0;
        my1             = '0;
        my2             = '0;
        in_flight       = 1'b0;
        exp_head        = '0;
        lat_head        = 0;
        cyc             = 0;
        in_count        = 0;
        out_count       = 0;
        err_data        = 0;
        err_timing      = 0;
        err_proto       = 0;
        rng_state       = 32'd48659;
        for (int k = 0; k < `IIR_TAPS; k++) begin
            cf[k] = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        apb_read(`REG_CTRL, 32'd0);
        apb_read(`REG_STATUS, 32'd0);
        for (int k = 0; k < `IIR_TAPS; k++) begin
            apb_read(`REG_COEF0 + 8'(4 * k), 32'd0);
        end

        test_name = "registers";
        set_coef(0, 32'hABC2_8000);
        set_coef(1, 32'h0001_FFFF);
        set_coef(2, 32'hFFFF_0001);
        set_coef(3, 32'h0002_0000);
        set_coef(4, 32'h1234_5678);
        apb_read(`REG_COEF0, sext18(32'hABC2_8000));
        apb_read(`REG_COEF1, sext18(32'h0001_FFFF));
        apb_read(`REG_COEF2, sext18(32'hFFFF_0001));
        apb_read(`REG_COEF3, sext18(32'h0002_0000));
        apb_read(`REG_COEF4, sext18(32'h1234_5678));
        apb_read(8'h1C, 32'd0);
        apb_write(8'h20, 32'hDEAD_BEEF);
        apb_read(8'h02, 32'd0);
        apb_read(`REG_COEF0, sext18(32'hABC2_8000));

        // b0 = 1.0 passes the input straight through
        test_name = "impulse";
        set_coef(0, 32'h0001_0000);
        set_coef(1, 32'h0);
        set_coef(2, 32'h0);
        set_coef(3, 32'h0);
        set_coef(4, 32'h0);
        apb_write(`REG_CTRL, 32'h1);
        send_sample(18'sd1);
        send_sample(-18'sd1);
        send_sample(18'sd131071);
        send_sample(-18'sd131072);
        send_sample(18'sd12345);
        send_sample(18'sd0);
        wait_idle();

        // Integrator with a -0.5 second tap where large inputs wrap
        test_name = "feedback";
        set_coef(3, 32'h0001_0000);
        set_coef(4, 32'h0003_8000);
        clear_history();
        send_sample(18'sd100000);
        send_sample(18'sd0);
        send_sample(18'sd90000);
        send_sample(18'sd0);
        send_sample(18'sd0);
        send_sample(-18'sd120000);
        send_sample(18'sd0);
        send_sample(18'sd0);
        wait_idle();

        test_name = "random";
        set_coef(0, 32'h0000_4000);
        set_coef(1, 32'h0000_8000);
        set_coef(2, 32'h0003_C000);
        set_coef(3, 32'h0000_C000);
        set_coef(4, 32'h0003_E000);
        for (int n = 0; n < N_RANDOM; n++) begin
            rng_state = xorshift32(rng_state);
            send_sample(sample_t'(rng_state[17:0]));
        end
        wait_idle();
        apb_read(`REG_STATUS, {16'd0, 16'(in_count)});

        // Disabled filter ignores a held sample
        test_name = "flow";
        apb_write(`REG_CTRL, 32'h0);
        sample_in       = 18'sd777;
        sample_in_valid = 1'b1;
        repeat (20) @(negedge clk);
        sample_in_valid = 1'b0;
        apb_write(`REG_CTRL, 32'h1);
        send_sample(18'sd777);
        send_sample(-18'sd5000);
        wait_idle();

        test_name = "clear";
        clear_history();
        send_sample(18'sd4096);
        // Busy shows while a sample is in process and the count lags by one
        apb_read(`REG_STATUS, {15'd0, 1'b1, 16'(in_count - 1)});
        send_sample(-18'sd70000);
        wait_idle();
        apb_read(`REG_STATUS, {16'd0, 16'(in_count)});

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            err_proto++;
            $display("Error: %0d expected outputs never appeared", exp_q.size());
        end
        $display("Errors: data %0d, timing %0d, protocol %0d, outputs seen %0d",
                 err_data, err_timing, err_proto, out_count);
        if (err_data + err_timing + err_proto == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== iir_filter_top.sv ====
// Single biquad with APB3 setup; no output back-pressure, result valid is a one-cycle pulse
`timescale 1ns/100ps

module iir_filter_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [7:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    input  iir_pkg::sample_t sample_in,
    input  logic             sample_in_valid,
    output logic             sample_in_ready,
    output iir_pkg::sample_t sample_out,
    output logic             sample_out_valid
);

    import iir_pkg::*;

    coef_t       coef0;
    coef_t       coef1;
    coef_t       coef2;
    coef_t       coef3;
    coef_t       coef4;
    logic        enable;
    logic        clear_hist;
    logic        busy;
    dsp_opmode_t opmode;
    coef_t       mul_a;
    sample_t     mul_b;
    acc_t        acc;

    // Register block, counts every result pulse
    iir_coef_regs iir_coef_regs_i (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .busy         (busy),
        .result_pulse (sample_out_valid),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .enable       (enable),
        .clear_hist   (clear_hist),
        .coef0        (coef0),
        .coef1        (coef1),
        .coef2        (coef2),
        .coef3        (coef3),
        .coef4        (coef4)
    );

    iir_biquad_seq iir_biquad_seq_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .clear_hist       (clear_hist),
        .coef0            (coef0),
        .coef1            (coef1),
        .coef2            (coef2),
        .coef3            (coef3),
        .coef4            (coef4),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .acc              (acc),
        .sample_in_ready  (sample_in_ready),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .busy             (busy),
        .opmode           (opmode),
        .mul_a            (mul_a),
        .mul_b            (mul_b)
    );

    // Shared multiply-accumulate slice
    dsp_mac dsp_mac_i (
        .clk    (clk),
        .reset  (reset),
        .opmode (opmode),
        .mul_a  (mul_a),
        .mul_b  (mul_b),
        .acc    (acc)
    );

endmodule

// ==== iir_biquad_seq.sv ====
// Fixed program for one biquad; result wraps to 18 bits, clear_hist is dropped unless idle
`timescale 1ns/100ps
`include "iir_consts.svh"

module iir_biquad_seq (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 clear_hist,
    input  iir_pkg::coef_t       coef0,
    input  iir_pkg::coef_t       coef1,
    input  iir_pkg::coef_t       coef2,
    input  iir_pkg::coef_t       coef3,
    input  iir_pkg::coef_t       coef4,
    input  iir_pkg::sample_t     sample_in,
    input  logic                 sample_in_valid,
    input  iir_pkg::acc_t        acc,
    output logic                 sample_in_ready,
    output iir_pkg::sample_t     sample_out,
    output logic                 sample_out_valid,
    output logic                 busy,
    output iir_pkg::dsp_opmode_t opmode,
    output iir_pkg::coef_t       mul_a,
    output iir_pkg::sample_t     mul_b
);

    import iir_pkg::*;

    // Task bits of a microcode step
    localparam seq_task_t T_WAIT_IN   = 16'h0001;
    localparam seq_task_t T_PUSH_X    = 16'h0002;
    localparam seq_task_t T_MUL_IN    = 16'h0004;
    localparam seq_task_t T_MUL_XY    = 16'h0008;
    localparam seq_task_t T_INC_I     = 16'h0010;
    localparam seq_task_t T_CLR_I     = 16'h0020;
    localparam seq_task_t T_RPT_TAPS  = 16'h0040;
    localparam seq_task_t T_RPT_DRAIN = 16'h0080;
    localparam seq_task_t T_CAPTURE   = 16'h0100;
    localparam seq_task_t T_PUSH_Y    = 16'h0200;
    localparam seq_task_t T_JP_0      = 16'h0400;

    // Six fixed steps plus the drain make up the latency; the MAC itself needs 3
    localparam int DRAIN_CYCLES = `IIR_LATENCY - 6;
    localparam int TAP_RPT      = `IIR_TAPS - 2;
    localparam int RES_LSB      = `IIR_FRAC_W;
    localparam int RES_MSB      = `IIR_FRAC_W + `IIR_SAMPLE_W - 1;

    logic [2:0] pc;
    seq_task_t  tasks;
    logic [3:0] rpt_cnt;
    logic [3:0] rpt_max;
    logic       rpt_hold;
    logic [2:0] idx;
    logic       idle;
    logic       accept;
    sample_t    sample_q;
    sample_t    xy_dly [`IIR_TAPS];
    coef_t      coefs [`IIR_TAPS];
    sample_t    result;

    // --------------------------------------------------
    // Microcode table
    // --------------------------------------------------
    always_comb begin
        case (pc)
            3'd0:    tasks = T_WAIT_IN;
            3'd1:    tasks = T_PUSH_X | T_MUL_IN | T_INC_I;
            3'd2:    tasks = T_RPT_TAPS | T_MUL_XY | T_INC_I;
            3'd3:    tasks = T_MUL_XY | T_CLR_I;
            3'd4:    tasks = T_RPT_DRAIN;
            3'd5:    tasks = T_CAPTURE | T_PUSH_Y;
            default: tasks = T_JP_0;
        endcase
    end

    assign idle            = (tasks & T_WAIT_IN) != '0;
    assign sample_in_ready = enable && idle;
    assign accept          = sample_in_valid && sample_in_ready;
    assign busy            = !idle;

    // Program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= 3'd0;
        end else if ((tasks & T_JP_0) != '0) begin
            pc <= 3'd0;
        end else if ((idle && !accept) || rpt_hold) begin
            pc <= pc;
        end else begin
            pc <= pc + 3'd1;
        end
    end

    // Repeat counter holds the pc on a repeated step
    always_comb begin
        if ((tasks & T_RPT_TAPS) != '0) begin
            rpt_max = 4'(TAP_RPT - 1);
        end else if ((tasks & T_RPT_DRAIN) != '0) begin
            rpt_max = 4'(DRAIN_CYCLES - 1);
        end else begin
            rpt_max = 4'd0;
        end
    end

    assign rpt_hold = (rpt_cnt != rpt_max);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rpt_cnt <= 4'd0;
        end else if (rpt_hold) begin
            rpt_cnt <= rpt_cnt + 4'd1;
        end else begin
            rpt_cnt <= 4'd0;
        end
    end

    // Index register, shared by coefficients and delay line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idx <= 3'd0;
        end else if ((tasks & T_CLR_I) != '0) begin
            idx <= 3'd0;
        end else if ((tasks & T_INC_I) != '0) begin
            idx <= idx + 3'd1;
        end
    end

    // --------------------------------------------------
    // Sample register and delay line
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            sample_q <= sample_in;
        end
    end

    assign result = acc[RES_MSB:RES_LSB];

    // Entries 0..2 are x0..x2, 3..4 are y1..y2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `IIR_TAPS; k++) begin
                xy_dly[k] <= '0;
            end
        end else if (idle && clear_hist) begin
            for (int k = 0; k < `IIR_TAPS; k++) begin
                xy_dly[k] <= '0;
            end
        end else if ((tasks & T_PUSH_X) != '0) begin
            xy_dly[0] <= sample_q;
            xy_dly[1] <= xy_dly[0];
            xy_dly[2] <= xy_dly[1];
        end else if ((tasks & T_PUSH_Y) != '0) begin
            xy_dly[3] <= result;
            xy_dly[4] <= xy_dly[3];
        end
    end

    assign coefs[0] = coef0;
    assign coefs[1] = coef1;
    assign coefs[2] = coef2;
    assign coefs[3] = coef3;
    assign coefs[4] = coef4;

    // --------------------------------------------------
    // MAC issue
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opmode <= `DSP_NOP;
        end else if ((tasks & T_MUL_IN) != '0) begin
            opmode <= `DSP_XIN_MULT | `DSP_ZIN_ZERO;
        end else if ((tasks & T_MUL_XY) != '0) begin
            opmode <= `DSP_XIN_MULT | `DSP_ZIN_POUT;
        end else begin
            opmode <= `DSP_NOP;
        end
    end

    // First product takes the new sample before it reaches the delay line
    always_ff @(posedge clk) begin
        if ((tasks & T_MUL_IN) != '0) begin
            mul_a <= coefs[idx];
            mul_b <= sample_q;
        end else if ((tasks & T_MUL_XY) != '0) begin
            mul_a <= coefs[idx];
            mul_b <= xy_dly[idx];
        end else begin
            mul_a <= '0;
            mul_b <= '0;
        end
    end

    // Result capture
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_valid <= 1'b0;
        end else begin
            sample_out_valid <= (tasks & T_CAPTURE) != '0;
        end
    end

    always_ff @(posedge clk) begin
        if ((tasks & T_CAPTURE) != '0) begin
            sample_out <= result;
        end
    end

endmodule

// ==== iir_coef_regs.sv ====
// APB3 slave, no wait states; coefficient writes act at once, so write them only while idle
`timescale 1ns/100ps
`include "iir_consts.svh"

module iir_coef_regs (
    input  logic            clk,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [7:0]      paddr,
    input  logic [31:0]     pwdata,
    input  logic            busy,
    input  logic            result_pulse,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            enable,
    output logic            clear_hist,
    output iir_pkg::coef_t  coef0,
    output iir_pkg::coef_t  coef1,
    output iir_pkg::coef_t  coef2,
    output iir_pkg::coef_t  coef3,
    output iir_pkg::coef_t  coef4
);

    import iir_pkg::*;

    coef_t       coef_q [`IIR_TAPS];
    logic [2:0]  coef_idx;
    logic        coef_hit;
    logic        ctrl_hit;
    logic        status_hit;
    logic        wr_en;
    logic [15:0] out_cnt;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    always_comb begin
        coef_hit   = 1'b0;
        coef_idx   = 3'd0;
        ctrl_hit   = 1'b0;
        status_hit = 1'b0;
        case (paddr)
            `REG_CTRL:   ctrl_hit = 1'b1;
            `REG_COEF0: begin
                coef_hit = 1'b1;
                coef_idx = 3'd0;
            end
            `REG_COEF1: begin
                coef_hit = 1'b1;
                coef_idx = 3'd1;
            end
            `REG_COEF2: begin
                coef_hit = 1'b1;
                coef_idx = 3'd2;
            end
            `REG_COEF3: begin
                coef_hit = 1'b1;
                coef_idx = 3'd3;
            end
            `REG_COEF4: begin
                coef_hit = 1'b1;
                coef_idx = 3'd4;
            end
            `REG_STATUS: status_hit = 1'b1;
            default: ;
        endcase
    end

    // Access phase write strobe
    assign wr_en   = psel && penable && pwrite;
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !(ctrl_hit || coef_hit || status_hit);

    // --------------------------------------------------
    // Register writes
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable     <= 1'b0;
            clear_hist <= 1'b0;
            for (int k = 0; k < `IIR_TAPS; k++) begin
                coef_q[k] <= '0;
            end
        end else begin
            // Self-clearing, high for one cycle
            clear_hist <= wr_en && ctrl_hit && pwdata[`CTRL_CLEAR_BIT];
            if (wr_en && ctrl_hit) begin
                enable <= pwdata[`CTRL_ENABLE_BIT];
            end
            if (wr_en && coef_hit) begin
                coef_q[coef_idx] <= coef_t'(pwdata[`IIR_SAMPLE_W-1:0]);
            end
        end
    end

    // Output counter, wraps at 16 bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_cnt <= 16'd0;
        end else if (result_pulse) begin
            out_cnt <= out_cnt + 16'd1;
        end
    end

    // Read mux, coefficients come back sign-extended
    always_comb begin
        prdata = 32'd0;
        if (psel && !pwrite) begin
            if (ctrl_hit) begin
                prdata[`CTRL_ENABLE_BIT] = enable;
            end else if (status_hit) begin
                prdata = {15'd0, busy, out_cnt};
            end else if (coef_hit) begin
                prdata = 32'(coef_q[coef_idx]);
            end
        end
    end

    assign coef0 = coef_q[0];
    assign coef1 = coef_q[1];
    assign coef2 = coef_q[2];
    assign coef3 = coef_q[3];
    assign coef4 = coef_q[4];

endmodule

// ==== dsp_mac.sv ====
// Behavioural DSP48-style MAC, three register stages; only the opmodes of the header are decoded
`timescale 1ns/100ps
`include "iir_consts.svh"

module dsp_mac (
    input  logic                 clk,
    input  logic                 reset,
    input  iir_pkg::dsp_opmode_t opmode,
    input  iir_pkg::coef_t       mul_a,
    input  iir_pkg::sample_t     mul_b,
    output iir_pkg::acc_t        acc
);

    import iir_pkg::*;

    localparam int PROD_W = 2 * `IIR_SAMPLE_W;

    dsp_opmode_t              op_in_q;
    dsp_opmode_t              op_prod_q;
    coef_t                    a_q;
    sample_t                  b_q;
    logic signed [PROD_W-1:0] prod_q;
    logic                     x_mult;
    logic                     z_pout;

    // --------------------------------------------------
    // Opmode pipeline, follows the data stage by stage
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_in_q   <= `DSP_NOP;
            op_prod_q <= `DSP_NOP;
        end else begin
            op_in_q   <= opmode;
            op_prod_q <= op_in_q;
        end
    end

    // Input and product registers
    always_ff @(posedge clk) begin
        a_q    <= mul_a;
        b_q    <= mul_b;
        prod_q <= a_q * b_q;
    end

    assign x_mult = (op_prod_q & `DSP_XIN_MASK) == `DSP_XIN_MULT;
    assign z_pout = (op_prod_q & `DSP_ZIN_MASK) == `DSP_ZIN_POUT;

    // Accumulate stage, no multiply in X means hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (x_mult) begin
            if (z_pout) begin
                acc <= acc + acc_t'(prod_q);
            end else begin
                acc <= acc_t'(prod_q);
            end
        end
    end

endmodule

// ==== iir_pkg.sv ====
// Types for a single biquad section; all widths follow the constants header
`include "iir_consts.svh"

package iir_pkg;

    // Signed input and output sample
    typedef logic signed [`IIR_SAMPLE_W-1:0] sample_t;

    // Q1.16 coefficient, feedback terms are stored negated
    typedef logic signed [`IIR_SAMPLE_W-1:0] coef_t;

    // MAC accumulator
    typedef logic signed [`IIR_ACC_W-1:0] acc_t;

    // DSP opmode word, X and Z fields
    typedef logic [7:0] dsp_opmode_t;

    // One microcode step, one bit per task
    typedef logic [15:0] seq_task_t;

endpackage

// ==== iir_consts.svh ====
// One biquad section only: 18-bit Q1.16 data, 8-bit APB offsets, latency fixed by the sequencer
`ifndef IIR_CONSTS_SVH
`define IIR_CONSTS_SVH

// Data path widths
`define IIR_SAMPLE_W 18
`define IIR_ACC_W    48
`define IIR_FRAC_W   16
`define IIR_TAPS     5

// DSP opmode fields: X in bits 1:0, Z in bits 3:2
`define DSP_NOP      8'h00
`define DSP_XIN_MULT 8'h01
`define DSP_ZIN_ZERO 8'h00
`define DSP_ZIN_POUT 8'h08
`define DSP_XIN_MASK 8'h03
`define DSP_ZIN_MASK 8'h0C

// APB byte offsets
`define REG_CTRL   8'h00
`define REG_COEF0  8'h04
`define REG_COEF1  8'h08
`define REG_COEF2  8'h0C
`define REG_COEF3  8'h10
`define REG_COEF4  8'h14
`define REG_STATUS 8'h18

// CTRL bits
`define CTRL_ENABLE_BIT 0
`define CTRL_CLEAR_BIT  1

// Accepted input to result pulse, in cycles
`define IIR_LATENCY 14

`endif
